// File: phold_pkg.sv
package phold_pkg;

	localparam int TIME_WID    = 16;
	localparam int NUM_LP      = 4;
	localparam int LP_WID      = 2;
	localparam int QUEUE_DEPTH = 8;  // Never fills, at most NUM_LP events live
	localparam int CNT_WID     = 4;
	localparam int INC_WID     = 4;

	localparam logic [TIME_WID-1:0] SIM_END_TIME = 16'd2000;

	// Base seed, each core XORs in its own index
	localparam logic [15:0] LFSR_SEED = 16'hACE1;

	typedef enum logic [2:0] {
		IDLE,
		INIT,
		READY,
		RUNNING,
		FINISHED
	} sim_state_t;

endpackage

// File: sim_ctrl.sv
`timescale 1ns/10ps

module sim_ctrl (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           start,
	input  logic                           load_last,
	input  logic [phold_pkg::TIME_WID-1:0] gvt,
	output logic                           load_en,
	output logic                           deq_allowed,
	output logic                           flush,
	output logic                           done,
	output logic                           busy
);

	phold_pkg::sim_state_t state;
	phold_pkg::sim_state_t state_nxt;
	logic                  fin_q;  // High during the FINISHED cycle

	always_comb begin
		state_nxt = state;
		case (state)
			phold_pkg::IDLE: begin
				if (start)
					state_nxt = phold_pkg::INIT;
			end
			phold_pkg::INIT: begin
				if (load_last)  // Last initial event goes in this cycle
					state_nxt = phold_pkg::READY;
			end
			phold_pkg::READY: begin
				state_nxt = phold_pkg::RUNNING;
			end
			phold_pkg::RUNNING: begin
				if (gvt > phold_pkg::SIM_END_TIME)
					state_nxt = phold_pkg::FINISHED;
			end
			phold_pkg::FINISHED: begin
				state_nxt = phold_pkg::IDLE;
			end
			default: begin
				state_nxt = phold_pkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= phold_pkg::IDLE;
			fin_q <= 1'b0;
		end else begin
			state <= state_nxt;
			fin_q <= (state_nxt == phold_pkg::FINISHED);
		end
	end

	assign load_en     = (state == phold_pkg::INIT);
	assign deq_allowed = (state == phold_pkg::RUNNING);
	assign busy        = (state != phold_pkg::IDLE);
	assign done        = fin_q;
	assign flush       = fin_q;  // Same cycle, clears queue, cores and tracker

endmodule

// File: init_seq_counter.sv
`timescale 1ns/10ps

module init_seq_counter (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         load_en,
	output logic [phold_pkg::LP_WID-1:0] load_lp,
	output logic                         load_last
);

	logic [phold_pkg::LP_WID-1:0] cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (load_en) begin
			cnt <= cnt + 1'b1;
		end else begin
			cnt <= '0;
		end
	end

	assign load_lp = cnt;

	// Final LP of the load sequence
	assign load_last = load_en && (int'(cnt) == phold_pkg::NUM_LP - 1);

endmodule

// File: event_queue.sv
`timescale 1ns/10ps

module event_queue (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           flush,
	input  logic                           enq,
	input  logic [phold_pkg::LP_WID-1:0]   enq_lp,
	input  logic [phold_pkg::TIME_WID-1:0] enq_time,
	input  logic                           deq,
	output logic [phold_pkg::LP_WID-1:0]   head_lp,
	output logic [phold_pkg::TIME_WID-1:0] head_time,
	output logic                           empty,
	output logic [phold_pkg::CNT_WID-1:0]  count
);

	logic [phold_pkg::LP_WID-1:0]      q_lp   [phold_pkg::QUEUE_DEPTH];
	logic [phold_pkg::TIME_WID-1:0]    q_time [phold_pkg::QUEUE_DEPTH];
	logic [phold_pkg::CNT_WID-1:0]     cnt;
	logic [phold_pkg::QUEUE_DEPTH-1:0] keep;

	// Valid entries not later than the new one stay in place
	always_comb begin
		for (int i = 0; i < phold_pkg::QUEUE_DEPTH; i++) begin
			keep[i] = (i < int'(cnt)) && (q_time[i] <= enq_time);
		end
	end

	always_ff @(posedge clk) begin
		if (enq) begin
			if (!keep[0]) begin
				q_lp[0]   <= enq_lp;
				q_time[0] <= enq_time;
			end
			for (int i = 1; i < phold_pkg::QUEUE_DEPTH; i++) begin
				if (!keep[i]) begin
					if (keep[i-1]) begin  // Insert point
						q_lp[i]   <= enq_lp;
						q_time[i] <= enq_time;
					end else begin
						q_lp[i]   <= q_lp[i-1];
						q_time[i] <= q_time[i-1];
					end
				end
			end
		end else if (deq) begin
			for (int i = 0; i < phold_pkg::QUEUE_DEPTH - 1; i++) begin
				q_lp[i]   <= q_lp[i+1];
				q_time[i] <= q_time[i+1];
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (flush) begin
			cnt <= '0;
		end else if (enq) begin
			cnt <= cnt + 1'b1;
		end else if (deq) begin
			cnt <= cnt - 1'b1;
		end
	end

	assign head_lp   = q_lp[0];
	assign head_time = q_time[0];
	assign empty     = (cnt == '0);
	assign count     = cnt;

endmodule

// File: rr_arbiter.sv
`timescale 1ns/10ps

module rr_arbiter (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic [phold_pkg::NUM_LP-1:0] req,
	input  logic                         advance,
	output logic [phold_pkg::NUM_LP-1:0] gnt,
	output logic [phold_pkg::LP_WID-1:0] gnt_idx,
	output logic                         any
);

	logic [phold_pkg::LP_WID-1:0] ptr;  // Highest priority requester

	always_comb begin
		logic [phold_pkg::LP_WID-1:0] idx;
		gnt     = '0;
		gnt_idx = '0;
		any     = 1'b0;
		for (int k = 0; k < phold_pkg::NUM_LP; k++) begin
			idx = ptr + k[phold_pkg::LP_WID-1:0];  // Wraps around
			if (!any && req[idx]) begin
				any     = 1'b1;
				gnt_idx = idx;
			end
		end
		gnt[gnt_idx] = any;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ptr <= '0;
		end else if (advance && any) begin
			ptr <= gnt_idx + 1'b1;
		end
	end

endmodule

// File: lp_core.sv
`timescale 1ns/10ps

module lp_core #(
	parameter int CORE_ID = 0
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           flush,
	input  logic                           ev_valid,
	input  logic [phold_pkg::LP_WID-1:0]   ev_lp,
	input  logic [phold_pkg::TIME_WID-1:0] ev_time,
	output logic                           ready,
	output logic                           child_valid,
	input  logic                           child_ready,
	output logic [phold_pkg::LP_WID-1:0]   child_lp,
	output logic [phold_pkg::TIME_WID-1:0] child_time,
	output logic [phold_pkg::TIME_WID-1:0] cur_time
);

	typedef logic [phold_pkg::TIME_WID-1:0] time_t;

	logic [15:0]                   lfsr;
	logic [15:0]                   lfsr_nxt;
	logic                          busy;
	logic                          accept;
	logic [1:0]                    delay;  // Processing cycles left minus one
	logic [phold_pkg::INC_WID-1:0] inc;

	// Galois form, taps 16 14 13 11
	assign lfsr_nxt = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hB400 : 16'h0000);

	assign ready  = !busy;
	assign accept = ev_valid && !busy;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lfsr        <= phold_pkg::LFSR_SEED ^ 16'(CORE_ID);
			busy        <= 1'b0;
			child_valid <= 1'b0;
			delay       <= '0;
		end else if (flush) begin
			busy        <= 1'b0;
			child_valid <= 1'b0;
		end else if (accept) begin
			lfsr  <= lfsr_nxt;
			busy  <= 1'b1;
			delay <= lfsr[7:6];
		end else if (busy && !child_valid) begin
			if (delay == 2'd0)
				child_valid <= 1'b1;
			else
				delay <= delay - 1'b1;
		end else if (child_valid && child_ready) begin
			child_valid <= 1'b0;  // Child granted, core free again
			busy        <= 1'b0;
		end
	end

	// Payload, taken from the value before the step
	always_ff @(posedge clk) begin
		if (accept) begin
			cur_time <= ev_time;
			inc      <= lfsr[phold_pkg::INC_WID-1:0];
			child_lp <= lfsr[5:4];
		end
	end

	assign child_time = cur_time + time_t'(inc) + time_t'(1);

endmodule

// File: gvt_tracker.sv
`timescale 1ns/10ps

module gvt_tracker (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           flush,
	input  logic                           disp_valid,
	input  logic [phold_pkg::LP_WID-1:0]   disp_core,
	input  logic [phold_pkg::TIME_WID-1:0] disp_time,
	input  logic                           child_taken,
	input  logic [phold_pkg::LP_WID-1:0]   child_core,
	input  logic [phold_pkg::TIME_WID-1:0] head_time,
	input  logic                           queue_empty,
	input  logic                           run_en,
	output logic [phold_pkg::TIME_WID-1:0] gvt
);

	logic [phold_pkg::TIME_WID-1:0] core_time [phold_pkg::NUM_LP];
	logic [phold_pkg::NUM_LP-1:0]   core_vld;
	logic [phold_pkg::TIME_WID-1:0] min_time;

	always_comb begin
		min_time = queue_empty ? '1 : head_time;
		for (int i = 0; i < phold_pkg::NUM_LP; i++) begin
			if (core_vld[i] && core_time[i] < min_time)
				min_time = core_time[i];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			core_vld <= '0;
			gvt      <= '0;
		end else if (flush) begin
			core_vld <= '0;
			gvt      <= '0;
		end else begin
			if (disp_valid)
				core_vld[disp_core] <= 1'b1;
			if (child_taken)
				core_vld[child_core] <= 1'b0;
			if (run_en)
				gvt <= min_time;
		end
	end

	always_ff @(posedge clk) begin
		if (disp_valid)
			core_time[disp_core] <= disp_time;
	end

endmodule

// File: phold_top.sv
`timescale 1ns/10ps

module phold_top (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           start,
	output logic                           busy,
	output logic                           done,
	output logic [phold_pkg::TIME_WID-1:0] gvt,
	output logic                           disp_valid,
	output logic [phold_pkg::LP_WID-1:0]   disp_core,
	output logic [phold_pkg::LP_WID-1:0]   disp_lp,
	output logic [phold_pkg::TIME_WID-1:0] disp_time,
	output logic                           gen_valid,
	output logic [phold_pkg::LP_WID-1:0]   gen_core,
	output logic [phold_pkg::LP_WID-1:0]   gen_lp,
	output logic [phold_pkg::TIME_WID-1:0] gen_time
);

	logic                           load_en;
	logic                           load_last;
	logic [phold_pkg::LP_WID-1:0]   load_lp;
	logic                           deq_allowed;
	logic                           flush;
	logic                           enq;
	logic [phold_pkg::LP_WID-1:0]   enq_lp;
	logic [phold_pkg::TIME_WID-1:0] enq_time;
	logic                           q_empty;
	logic [phold_pkg::CNT_WID-1:0]  q_count;
	logic                           disp_any;
	logic [phold_pkg::NUM_LP-1:0]   disp_gnt;
	logic [phold_pkg::NUM_LP-1:0]   core_ready;
	logic [phold_pkg::NUM_LP-1:0]   child_valid;
	logic [phold_pkg::NUM_LP-1:0]   child_ready;
	logic [phold_pkg::LP_WID-1:0]   child_lp   [phold_pkg::NUM_LP];
	logic [phold_pkg::TIME_WID-1:0] child_time [phold_pkg::NUM_LP];

	sim_ctrl u_ctrl (
		.clk(clk), .rst_n(rst_n), .start(start), .load_last(load_last), .gvt(gvt),
		.load_en(load_en), .deq_allowed(deq_allowed), .flush(flush),
		.done(done), .busy(busy)
	);

	init_seq_counter u_init (
		.clk(clk), .rst_n(rst_n), .load_en(load_en),
		.load_lp(load_lp), .load_last(load_last)
	);

	// Initial loads at time zero, otherwise the granted child
	assign enq      = load_en || gen_valid;
	assign enq_lp   = load_en ? load_lp : gen_lp;
	assign enq_time = load_en ? '0 : gen_time;

	// Children win over dispatch
	assign disp_valid = deq_allowed && !q_empty && !gen_valid && disp_any;

	event_queue u_queue (
		.clk(clk), .rst_n(rst_n), .flush(flush),
		.enq(enq), .enq_lp(enq_lp), .enq_time(enq_time), .deq(disp_valid),
		.head_lp(disp_lp), .head_time(disp_time), .empty(q_empty), .count(q_count)
	);

	rr_arbiter disp_arb (
		.clk(clk), .rst_n(rst_n), .req(core_ready), .advance(disp_valid),
		.gnt(disp_gnt), .gnt_idx(disp_core), .any(disp_any)
	);

	rr_arbiter gen_arb (
		.clk(clk), .rst_n(rst_n), .req(child_valid), .advance(gen_valid),
		.gnt(child_ready), .gnt_idx(gen_core), .any(gen_valid)
	);

	assign gen_lp   = child_lp[gen_core];
	assign gen_time = child_time[gen_core];

	for (genvar g = 0; g < phold_pkg::NUM_LP; g++) begin : gen_lp_core
		lp_core #(.CORE_ID(g)) u_core (
			.clk(clk), .rst_n(rst_n), .flush(flush),
			.ev_valid(disp_valid && disp_gnt[g]), .ev_lp(disp_lp), .ev_time(disp_time),
			.ready(core_ready[g]),
			.child_valid(child_valid[g]), .child_ready(child_ready[g]),
			.child_lp(child_lp[g]), .child_time(child_time[g]),
			.cur_time()
		);
	end

	gvt_tracker u_gvt (
		.clk(clk), .rst_n(rst_n), .flush(flush),
		.disp_valid(disp_valid), .disp_core(disp_core), .disp_time(disp_time),
		.child_taken(gen_valid), .child_core(gen_core),
		.head_time(disp_time), .queue_empty(q_empty),
		.run_en(deq_allowed), .gvt(gvt)
	);

endmodule

// File: phold_asserts.sv
`timescale 1ns/10ps

module phold_asserts (
	input logic                           clk,
	input logic                           rst_n,
	input logic                           busy,
	input logic                           done,
	input logic                           disp_valid,
	input logic                           gen_valid,
	input logic [phold_pkg::TIME_WID-1:0] gvt,
	input logic [phold_pkg::CNT_WID-1:0]  q_count
);

	done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
		else $error("done high for more than one cycle");

	disp_gen_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(disp_valid && gen_valid))
		else $error("dispatch and generation in the same cycle");

	// Min pending time only grows during a run
	gvt_rising: assert property (@(posedge clk) disable iff (!rst_n)
		(busy && $past(busy)) |-> gvt >= $past(gvt))
		else $error("gvt decreased while busy");

	queue_bound: assert property (@(posedge clk) disable iff (!rst_n)
		int'(q_count) <= phold_pkg::NUM_LP)
		else $error("queue holds more than NUM_LP events");

endmodule

bind phold_top phold_asserts u_asserts (
	.clk(clk), .rst_n(rst_n), .busy(busy), .done(done),
	.disp_valid(disp_valid), .gen_valid(gen_valid), .gvt(gvt), .q_count(q_count)
);

// File: phold_tb.sv
`timescale 1ns/10ps

module phold_tb;

	localparam int CLK_PERIOD = 100;
	localparam int NUM_RUNS   = 2;
	localparam int RUN_CYCLES = 10000;  // Upper estimate for one run
	localparam int LPW        = phold_pkg::LP_WID;
	localparam int TW         = phold_pkg::TIME_WID;
	localparam int NLP        = phold_pkg::NUM_LP;

	logic           clk, rst_n, start, busy, done, disp_valid, gen_valid;
	logic [LPW-1:0] disp_core, disp_lp, gen_core, gen_lp;
	logic [TW-1:0]  gvt, disp_time, gen_time;

	logic [15:0]    lfsr_m   [NLP];
	logic           held     [NLP];  // Core holds an event
	logic [LPW-1:0] exp_lp   [NLP];
	logic [TW-1:0]  exp_time [NLP];
	logic [TW-1:0]  par_time [NLP];
	logic [LPW-1:0] pend_lp   [$];
	logic [TW-1:0]  pend_time [$];
	logic           active, first_disp, after_done;
	int             busy_cycles, n_disp, n_gen;
	int             err_cnt = 0;
	int             runs_done = 0;

	phold_top dut (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Right shift, feedback into bits 15 13 12 10 for taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] v);
		logic [15:0] n;
		n = v >> 1;
		if (v[0])
			n = n ^ ((16'd1 << 15) | (16'd1 << 13) | (16'd1 << 12) | (16'd1 << 10));
		return n;
	endfunction

	// Child {lp, time} of an event at t, drawn from generator value rnd
	function automatic logic [LPW+TW-1:0] child_of(input logic [TW-1:0] t,
			input logic [15:0] rnd);
		logic [TW-1:0] ct;
		ct = t + TW'(rnd[phold_pkg::INC_WID-1:0]) + TW'(1);
		return {rnd[5:4], ct};
	endfunction

	function automatic logic [TW-1:0] lowest_time(input bit with_cores);
		logic [TW-1:0] m;
		m = '1;
		foreach (pend_time[i])
			if (pend_time[i] < m)
				m = pend_time[i];
		for (int c = 0; c < NLP; c++)
			if (with_cores && held[c] && par_time[c] < m)
				m = par_time[c];
		return m;
	endfunction

	always @(negedge clk) begin
		logic [TW-1:0]     mn;
		logic [LPW+TW-1:0] ch;
		int                hit;
		int                cnt;
		if (rst_n) begin
			if (after_done && busy) begin
				$display("error at %0t: busy still high after done", $time);
				err_cnt++;
			end
			after_done = 1'b0;
			if (busy && !active) begin  // Four zero-time events per start
				for (int i = 0; i < NLP; i++) begin
					pend_lp.push_back(LPW'(i));
					pend_time.push_back(TW'(0));
				end
				active = 1'b1;
				first_disp = 1'b1;
				busy_cycles = 0;
			end
			if (active) begin
				busy_cycles++;
				mn = lowest_time(1'b1);
				cnt = pend_time.size();
				for (int c = 0; c < NLP; c++)
					cnt += int'(!dut.core_ready[c]);  // Cores busy in the DUT
				if (gvt > mn) begin
					$display("mismatch at %0t: gvt %0d above lowest pending time %0d",
						$time, gvt, mn);
					err_cnt++;
				end
				if (cnt != NLP) begin
					$display("error at %0t: %0d events in flight instead of %0d",
						$time, cnt, NLP);
					err_cnt++;
				end
			end
			if (disp_valid) begin
				n_disp++;
				mn = lowest_time(1'b0);
				hit = -1;
				foreach (pend_time[i])
					if (hit < 0 && pend_time[i] == mn && pend_lp[i] == disp_lp)
						hit = i;
				if (first_disp && disp_time != TW'(0)) begin
					$display("mismatch at %0t: first dispatch at time %0d", $time, disp_time);
					err_cnt++;
				end
				first_disp = 1'b0;
				if (!active || busy_cycles <= NLP || pend_time.size() == 0) begin
					$display("error at %0t: dispatch during load or idle", $time);
					err_cnt++;
				end else if (disp_time != mn || hit < 0) begin
					$display("mismatch at %0t: dispatch lp %0d time %0d, lowest pending %0d",
						$time, disp_lp, disp_time, mn);
					err_cnt++;
				end else if (held[disp_core]) begin
					$display("error at %0t: dispatch to busy core %0d", $time, disp_core);
					err_cnt++;
				end else begin
					ch = child_of(mn, lfsr_m[disp_core]);
					exp_lp[disp_core]   = ch[LPW+TW-1:TW];
					exp_time[disp_core] = ch[TW-1:0];
					par_time[disp_core] = mn;
					held[disp_core]     = 1'b1;
					lfsr_m[disp_core]   = lfsr_step(lfsr_m[disp_core]);
					pend_lp.delete(hit);
					pend_time.delete(hit);
				end
			end
			if (gen_valid) begin
				n_gen++;
				if (!held[gen_core]) begin
					$display("error at %0t: child from core %0d, which holds no event",
						$time, gen_core);
					err_cnt++;
				end else begin
					if (gen_lp != exp_lp[gen_core] || gen_time != exp_time[gen_core]) begin
						$display("mismatch at %0t: core %0d child %0d@%0d, expected %0d@%0d",
							$time, gen_core, gen_lp, gen_time,
							exp_lp[gen_core], exp_time[gen_core]);
						err_cnt++;
					end
					pend_lp.push_back(exp_lp[gen_core]);
					pend_time.push_back(exp_time[gen_core]);
					held[gen_core] = 1'b0;
				end
			end
			if (done) begin
				if (!active || gvt <= phold_pkg::SIM_END_TIME) begin
					$display("error at %0t: done while gvt %0d not past end time", $time, gvt);
					err_cnt++;
				end
				pend_lp.delete();
				pend_time.delete();
				for (int c = 0; c < NLP; c++)
					held[c] = 1'b0;
				active = 1'b0;
				after_done = 1'b1;
				runs_done++;
			end
		end
	end

	initial begin
		int gap;
		int err_before;
		int passed;
		passed = 0;
		rst_n = 1'b0;
		start = 1'b0;
		active = 1'b0;
		after_done = 1'b0;
		first_disp = 1'b0;
		for (int c = 0; c < NLP; c++) begin
			lfsr_m[c] = phold_pkg::LFSR_SEED ^ 16'(c);
			held[c] = 1'b0;
		end
		void'($urandom(32'h06df_bd12));
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		for (int r = 0; r < NUM_RUNS; r++) begin
			err_before = err_cnt;
			n_disp = 0;
			n_gen = 0;
			gap = int'($urandom_range(10, 1));
			repeat (gap) @(posedge clk);
			start <= 1'b1;
			@(posedge clk);
			start <= 1'b0;
			while (runs_done <= r)
				@(posedge clk);
			@(posedge clk);  // Lets the idle check after done run
			if (err_cnt == err_before) begin
				passed++;
				$display("run %0d passed: %0d dispatches, %0d children", r + 1, n_disp, n_gen);
			end else begin
				$display("run %0d failed: %0d errors", r + 1, err_cnt - err_before);
			end
		end
		$display("%0d of %0d runs passed, %0d errors", passed, NUM_RUNS, err_cnt);
		if (err_cnt == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial begin
		#(NUM_RUNS * RUN_CYCLES * CLK_PERIOD);
		$display("timeout: runs did not finish within %0d cycles", NUM_RUNS * RUN_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// File: filelist.f
phold_pkg.sv
sim_ctrl.sv
init_seq_counter.sv
event_queue.sv
rr_arbiter.sv
lp_core.sv
gvt_tracker.sv
phold_top.sv
phold_asserts.sv
phold_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module phold_tb -f filelist.f -o phold_sim
./obj_dir/phold_sim | tee sim.log

# Pass only if the testbench printed its pass line
grep -q "TEST OK" sim.log
